// File: Makefile
VERILATOR ?= verilator
TOP       := tb_input_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
+incdir+verilog
verilog/input_pkg.sv
verilog/keypad_scanner.sv
verilog/input_unit.sv
verilog/input_top.sv
sim/input_assert.sv
sim/tb_input_top.sv

// File: sim/input_assert.sv
`timescale 1ns/10ps

`include "input_consts.svh"

module input_assert
    import input_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input key_code_t    key_coord,
    input logic         cpu_pause,
    input logic         switch_enable,
    input input_state_t input_state,
    input digit_cnt_t   digit_cnt
);

    localparam digit_cnt_t DIGIT_MAX = digit_cnt_t'(`MAX_DIGITS);

    // both are registered on the same edge
    pause_matches_halt: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_pause == (input_state == ST_HALT))
        else $error("cpu_pause disagrees with the halt state");

    switch_matches_state: assert property (@(posedge clk) disable iff (!rst_n)
        switch_enable == (input_state == ST_SWITCH))
        else $error("switch_enable disagrees with the switch state");

    // scanner output, one cycle per press
    key_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
        (key_coord != '0) |=> (key_coord == '0))
        else $error("key code held for more than one cycle");

    digit_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        digit_cnt <= DIGIT_MAX)
        else $error("digit count above the limit");

endmodule

// File: sim/tb_input_top.sv
`timescale 1ns/10ps

`include "input_consts.svh"

module tb_input_top
    import input_pkg::*;
();

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 5;
    localparam int SCAN_LEN     = 4 * `SCAN_CYCLES;            // cycles for one full scan
    localparam int HOLD_SCANS   = 6;
    localparam int PRESS_CYCLES = 2 * HOLD_SCANS * SCAN_LEN;   // hold plus release
    localparam int N_PRESSES    = 37;                          // presses over all tests
    localparam int TIMEOUT_NS   = 2 * (N_PRESSES * PRESS_CYCLES + RESET_CYCLES + 100) * CLK_NS;

    logic         clk = 1'b0;
    logic         rst_n;
    nibble_t      row;
    nibble_t      col;
    switch_t      switch_map;
    logic         input_enable;
    logic         uart_complete;
    word_t        input_data;
    logic         input_complete;
    logic         switch_enable;
    logic         cpu_pause;
    input_state_t input_state;

    key_code_t    key_held;        // key the operator is holding down, 0 when none
    logic         prev_complete;   // memory model edge detect
    integer       seed = 32'hc210;
    int           err_cnt;
    int           check_cnt;
    int           test_cnt;
    int           test_err_start;
    string        cur_test;

    always #(CLK_NS / 2) clk = ~clk;

    // keypad model, the held key pulls its row low while its column is driven
    assign row = ((key_held != '0) && (col == key_held[3:0])) ? key_held[7:4] : 4'hF;

    input_top i_input_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .row            (row),
        .col            (col),
        .switch_map     (switch_map),
        .input_enable   (input_enable),
        .uart_complete  (uart_complete),
        .input_data     (input_data),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .input_state    (input_state)
    );

    // the key pulse is checked where it enters the controller
    bind input_unit input_assert i_input_assert (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_coord     (key_coord),
        .cpu_pause     (cpu_pause),
        .switch_enable (switch_enable),
        .input_state   (input_state),
        .digit_cnt     (digit_cnt)
    );

    // one falling edge; data memory drops its request once the value is confirmed
    task automatic tick();
        @(negedge clk);
        if (input_complete && !prev_complete)
            input_enable = 1'b0;
        prev_complete = input_complete;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) tick();
    endtask

    task automatic press_key(input key_code_t k);
        key_held = k;
        wait_cycles(HOLD_SCANS * SCAN_LEN);
        key_held = '0;
        wait_cycles(HOLD_SCANS * SCAN_LEN);   // long enough for a debounced release
    endtask

    task automatic request_input();
        input_enable = 1'b1;
        wait_cycles(2);
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("[FAIL] %s %s: expected %0d (0x%h), actual %0d (0x%h)",
                     cur_test, what, exp, exp, act, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = err_cnt;
        test_cnt++;
    endtask

    task automatic finish_test();
        if (err_cnt == test_err_start)
            $display("test %s: ok", cur_test);
        else
            $display("test %s: %0d errors", cur_test, err_cnt - test_err_start);
    endtask

    function automatic int rand_digit();
        return {$random(seed)} % 10;
    endfunction

    function automatic key_code_t digit_key(input int d);
        case (d)
            1:       return KEY_1;
            2:       return KEY_2;
            3:       return KEY_3;
            4:       return KEY_4;
            5:       return KEY_5;
            6:       return KEY_6;
            7:       return KEY_7;
            8:       return KEY_8;
            9:       return KEY_9;
            default: return KEY_0;
        endcase
    endfunction

    task automatic test_reset();
        start_test("reset");
        check_val("state", 32'(ST_BLOCK), 32'(input_state));
        check_val("input_complete", 32'(1'b0), 32'(input_complete));
        check_val("switch_enable", 32'(1'b0), 32'(switch_enable));
        check_val("cpu_pause", 32'(1'b0), 32'(cpu_pause));
        check_val("input_data", 32'd0, input_data);
        check_val("col", 32'(4'b1110), 32'(col));   // first column still driven
        finish_test();
    endtask

    task automatic test_number_entry();
        int   d;
        int   exp;
        start_test("number_entry");
        exp = 0;
        request_input();
        check_val("state", 32'(ST_KEYPAD), 32'(input_state));
        repeat (5) begin
            d   = rand_digit();
            exp = exp * 10 + d;
            press_key(digit_key(d));
        end
        check_val("number", exp, input_data);
        press_key(KEY_ENTER);
        check_val("input_complete", 32'(1'b1), 32'(input_complete));
        check_val("state", 32'(ST_BLOCK), 32'(input_state));
        check_val("result", exp, input_data);
        finish_test();
    endtask

    task automatic test_edit();
        int d;
        int exp;
        start_test("edit");
        request_input();
        press_key(KEY_BACKSPACE);   // nothing typed yet
        check_val("empty backspace", 32'd0, input_data);
        exp = 0;
        for (int i = 0; i < 3; i++) begin
            d = rand_digit();
            if (i < 2)
                exp = exp * 10 + d;
            press_key(digit_key(d));
        end
        press_key(KEY_BACKSPACE);
        check_val("after backspace", exp, input_data);
        press_key(KEY_ENTER);
        check_val("backspace result", exp, input_data);
        request_input();
        check_val("cleared", 32'd0, input_data);
        check_val("complete cleared", 32'(1'b0), 32'(input_complete));
        exp = 0;
        for (int i = 0; i < 10; i++) begin
            d = rand_digit();
            if (i < `MAX_DIGITS)
                exp = exp * 10 + d;
            press_key(digit_key(d));
        end
        check_val("digit limit", exp, input_data);
        press_key(KEY_ENTER);
        check_val("limit complete", 32'(1'b1), 32'(input_complete));
        check_val("limit result", exp, input_data);
        finish_test();
    endtask

    task automatic test_switch_source();
        int            exp;
        int            d;
        logic [31:0]   sw_rand;
        start_test("switch_source");
        sw_rand    = $random(seed);
        switch_map = sw_rand[`SWITCH_CNT-1:0];
        request_input();
        exp = 0;
        repeat (2) begin
            d   = rand_digit();
            exp = exp * 10 + d;
            press_key(digit_key(d));
        end
        press_key(KEY_TOGGLE);
        check_val("switch_enable on", 32'(1'b1), 32'(switch_enable));
        check_val("state switch", 32'(ST_SWITCH), 32'(input_state));
        check_val("switch data", 32'(switch_map), input_data);
        press_key(KEY_TOGGLE);
        check_val("switch_enable off", 32'(1'b0), 32'(switch_enable));
        check_val("state keypad", 32'(ST_KEYPAD), 32'(input_state));
        check_val("number back", exp, input_data);
        press_key(KEY_TOGGLE);
        press_key(KEY_ENTER);
        check_val("input_complete", 32'(1'b1), 32'(input_complete));
        check_val("state block", 32'(ST_BLOCK), 32'(input_state));
        check_val("switch_enable low", 32'(1'b0), 32'(switch_enable));
        check_val("switch result", 32'(switch_map), input_data);
        finish_test();
    endtask

    task automatic test_pause();
        start_test("pause");
        uart_complete = 1'b0;
        press_key(KEY_PAUSE);
        check_val("state halt", 32'(ST_HALT), 32'(input_state));
        check_val("cpu_pause on", 32'(1'b1), 32'(cpu_pause));
        press_key(KEY_PAUSE);   // loader not finished
        check_val("halt kept", 32'(ST_HALT), 32'(input_state));
        uart_complete = 1'b1;
        press_key(KEY_PAUSE);
        check_val("state resumed", 32'(ST_BLOCK), 32'(input_state));
        check_val("cpu_pause off", 32'(1'b0), 32'(cpu_pause));
        uart_complete = 1'b0;
        finish_test();
    endtask

    task automatic test_enable_drop();
        int d;
        int exp;
        start_test("enable_drop");
        request_input();
        exp = 0;
        repeat (3) begin
            d   = rand_digit();
            exp = exp * 10 + d;
            press_key(digit_key(d));
        end
        input_enable = 1'b0;
        wait_cycles(2);
        check_val("state block", 32'(ST_BLOCK), 32'(input_state));
        check_val("number kept", exp, input_data);
        repeat (2) press_key(digit_key(rand_digit()));
        check_val("digits ignored", exp, input_data);
        check_val("still block", 32'(ST_BLOCK), 32'(input_state));
        finish_test();
    endtask

    initial begin
        rst_n         = 1'b0;
        key_held      = '0;
        switch_map    = '0;
        input_enable  = 1'b0;
        uart_complete = 1'b0;
        prev_complete = 1'b0;
        err_cnt       = 0;
        check_cnt     = 0;
        test_cnt      = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        tick();
        test_reset();
        test_number_entry();
        test_edit();
        test_switch_source();
        test_pause();
        test_enable_drop();
        $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: verilog/input_consts.svh
`ifndef INPUT_CONSTS_SVH
`define INPUT_CONSTS_SVH

// width of the data word handed to data memory
`define ISA_WIDTH       32

// toggle switch bank on the board
`define SWITCH_CNT      16

// longest decimal number the operator can type
`define MAX_DIGITS      8

// cycles each keypad column stays driven low
// small value for simulation, a board build needs a much longer dwell
`define SCAN_CYCLES     4

// full scans with the same reading before a press or release counts
`define DEBOUNCE_SCANS  3

`endif

// File: verilog/input_pkg.sv
`include "input_consts.svh"

package input_pkg;

    typedef logic [`ISA_WIDTH-1:0]  word_t;      // data word to memory
    typedef logic [`SWITCH_CNT-1:0] switch_t;    // toggle switch bank
    typedef logic [7:0]             key_code_t;  // {row, col}, each active low, 0 = no key
    typedef logic [3:0]             nibble_t;    // one row or column vector
    typedef logic [3:0]             digit_cnt_t; // digits typed so far

    typedef enum logic [1:0] {
        ST_BLOCK  = 2'b00,  // waiting for data memory to ask
        ST_SWITCH = 2'b01,  // switches are the source
        ST_KEYPAD = 2'b10,  // number entry on the keypad
        ST_HALT   = 2'b11   // cpu paused
    } input_state_t;

    // keypad layout, row nibble then column nibble
    localparam key_code_t KEY_1         = 8'b1110_1110;
    localparam key_code_t KEY_2         = 8'b1110_1101;
    localparam key_code_t KEY_3         = 8'b1110_1011;
    localparam key_code_t KEY_PAUSE     = 8'b1110_0111;  // "A"
    localparam key_code_t KEY_4         = 8'b1101_1110;
    localparam key_code_t KEY_5         = 8'b1101_1101;
    localparam key_code_t KEY_6         = 8'b1101_1011;
    localparam key_code_t KEY_TOGGLE    = 8'b1101_0111;  // "B"
    localparam key_code_t KEY_7         = 8'b1011_1110;
    localparam key_code_t KEY_8         = 8'b1011_1101;
    localparam key_code_t KEY_9         = 8'b1011_1011;
    localparam key_code_t KEY_C         = 8'b1011_0111;  // unused
    localparam key_code_t KEY_BACKSPACE = 8'b0111_1110;  // "*"
    localparam key_code_t KEY_0         = 8'b0111_1101;
    localparam key_code_t KEY_ENTER     = 8'b0111_1011;  // "#"
    localparam key_code_t KEY_D         = 8'b0111_0111;  // unused

endpackage

// File: verilog/input_top.sv
`timescale 1ns/10ps

module input_top
    import input_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  nibble_t      row,             // keypad rows, active low
    output nibble_t      col,             // keypad columns, active low
    input  switch_t      switch_map,
    input  logic         input_enable,    // from data memory
    input  logic         uart_complete,   // from the uart loader
    output word_t        input_data,
    output logic         input_complete,
    output logic         switch_enable,   // also tells the display what is shown
    output logic         cpu_pause,
    output input_state_t input_state
);

    key_code_t key_coord;   // one pulse per key press

    keypad_scanner i_keypad_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .row       (row),
        .col       (col),
        .key_coord (key_coord)
    );

    input_unit i_input_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_coord      (key_coord),
        .switch_map     (switch_map),
        .uart_complete  (uart_complete),
        .input_enable   (input_enable),
        .input_complete (input_complete),
        .input_data     (input_data),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .input_state    (input_state)
    );

endmodule

// File: verilog/input_unit.sv
`timescale 1ns/10ps

`include "input_consts.svh"

module input_unit
    import input_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  key_code_t    key_coord,       // press pulse from the scanner
    input  switch_t      switch_map,      // toggle switches
    input  logic         uart_complete,   // upload finished, resume allowed
    input  logic         input_enable,    // data memory is waiting for input
    output logic         input_complete,  // operator confirmed the value
    output word_t        input_data,      // value for data memory
    output logic         switch_enable,   // switches are being used
    output logic         cpu_pause,
    output input_state_t input_state
);

    localparam word_t      TEN       = word_t'(10);
    localparam digit_cnt_t DIGIT_MAX = digit_cnt_t'(`MAX_DIGITS);
    localparam int         PAD_W     = `ISA_WIDTH - `SWITCH_CNT;

    word_t      keypad_data;   // assembled decimal number
    digit_cnt_t digit_cnt;
    logic       src_switch;    // last source picked was the switches
    logic       digit_hit;
    logic [3:0] digit_val;

    // source stays on the switches after enter so memory reads the switch value
    assign input_data = src_switch ? {{PAD_W{1'b0}}, switch_map} : keypad_data;

    always_comb begin
        digit_hit = 1'b1;
        digit_val = 4'd0;
        case (key_coord)
            KEY_0:   digit_val = 4'd0;
            KEY_1:   digit_val = 4'd1;
            KEY_2:   digit_val = 4'd2;
            KEY_3:   digit_val = 4'd3;
            KEY_4:   digit_val = 4'd4;
            KEY_5:   digit_val = 4'd5;
            KEY_6:   digit_val = 4'd6;
            KEY_7:   digit_val = 4'd7;
            KEY_8:   digit_val = 4'd8;
            KEY_9:   digit_val = 4'd9;
            default: digit_hit = 1'b0;   // idle, C, D and command keys
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            input_state    <= ST_BLOCK;
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
            src_switch     <= 1'b0;
            keypad_data    <= '0;
            digit_cnt      <= '0;
        end else begin
            case (input_state)
                ST_BLOCK: begin
                    if (key_coord == KEY_PAUSE) begin
                        input_state <= ST_HALT;
                        cpu_pause   <= 1'b1;
                    end else if (input_enable) begin
                        input_state    <= ST_KEYPAD;
                        input_complete <= 1'b0;
                        src_switch     <= 1'b0;
                        keypad_data    <= '0;
                        digit_cnt      <= '0;
                    end
                end
                ST_KEYPAD: begin
                    if (!input_enable) begin
                        input_state <= ST_BLOCK;   // memory withdrew the request
                    end else begin
                        case (key_coord)
                            KEY_TOGGLE: begin
                                input_state   <= ST_SWITCH;
                                switch_enable <= 1'b1;
                                src_switch    <= 1'b1;
                            end
                            KEY_BACKSPACE: begin
                                if (digit_cnt != '0) begin
                                    keypad_data <= keypad_data / TEN;
                                    digit_cnt   <= digit_cnt - 1'b1;
                                end
                            end
                            KEY_ENTER: begin
                                input_state    <= ST_BLOCK;
                                input_complete <= 1'b1;
                                digit_cnt      <= '0;
                            end
                            KEY_PAUSE: begin
                                input_state    <= ST_HALT;
                                input_complete <= 1'b1;
                                cpu_pause      <= 1'b1;
                                digit_cnt      <= '0;
                            end
                            default: begin
                                if (digit_hit && (digit_cnt < DIGIT_MAX)) begin
                                    keypad_data <= keypad_data * TEN + word_t'(digit_val);
                                    digit_cnt   <= digit_cnt + 1'b1;
                                end
                            end
                        endcase
                    end
                end
                ST_SWITCH: begin
                    case (key_coord)
                        KEY_TOGGLE: begin
                            input_state   <= ST_KEYPAD;   // back to the typed number
                            switch_enable <= 1'b0;
                            src_switch    <= 1'b0;
                        end
                        KEY_ENTER: begin
                            input_state    <= ST_BLOCK;
                            input_complete <= 1'b1;
                            switch_enable  <= 1'b0;
                            digit_cnt      <= '0;
                        end
                        KEY_PAUSE: begin
                            input_state    <= ST_HALT;
                            input_complete <= 1'b1;
                            switch_enable  <= 1'b0;
                            cpu_pause      <= 1'b1;
                            digit_cnt      <= '0;
                        end
                        default: ;
                    endcase
                end
                ST_HALT: begin
                    // resume only once the loader is done
                    if (uart_complete && (key_coord == KEY_PAUSE)) begin
                        input_state <= ST_BLOCK;
                        cpu_pause   <= 1'b0;
                    end
                end
                default: input_state <= ST_BLOCK;
            endcase
        end
    end

endmodule

// File: verilog/keypad_scanner.sv
`timescale 1ns/10ps

`include "input_consts.svh"

module keypad_scanner
    import input_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  nibble_t   row,        // keypad rows, low while a key in the driven column is down
    output nibble_t   col,        // one column driven low at a time
    output key_code_t key_coord   // one-cycle {row, col} pulse per debounced press
);

    localparam int CNT_W = (`SCAN_CYCLES > 1) ? $clog2(`SCAN_CYCLES) : 1;
    localparam int DB_W  = $clog2(`DEBOUNCE_SCANS + 1);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SCAN_CYCLES - 1);
    localparam logic [DB_W-1:0]  DB_FULL  = DB_W'(`DEBOUNCE_SCANS);
    localparam nibble_t          FIRST_COL = 4'b1110;
    localparam nibble_t          LAST_COL  = 4'b0111;
    localparam nibble_t          ROW_IDLE  = 4'b1111;

    logic [CNT_W-1:0] scan_cnt;    // cycles spent on the current column
    logic [DB_W-1:0]  stable_cnt;  // scans in a row with the same reading
    logic [DB_W-1:0]  next_cnt;
    key_code_t        scan_code;   // key found so far in this scan
    key_code_t        last_read;   // result of the previous full scan
    key_code_t        reading;
    logic             pressed;     // a debounced press is still held
    logic             col_end;
    logic             scan_end;
    logic             hit;

    assign col_end  = (scan_cnt == CNT_LAST);       // rows have settled by now
    assign scan_end = col_end && (col == LAST_COL);
    assign hit      = (row != ROW_IDLE);

    // a hit on the current column overrides what earlier columns found
    always_comb begin
        if (hit)
            reading = {row, col};
        else
            reading = scan_code;
    end

    always_comb begin
        if (reading != last_read)
            next_cnt = DB_W'(1);         // new reading starts its own run
        else if (stable_cnt == DB_FULL)
            next_cnt = DB_FULL;          // saturate while held
        else
            next_cnt = stable_cnt + 1'b1;
    end

    // column rotation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            col      <= FIRST_COL;
        end else if (col_end) begin
            scan_cnt <= '0;
            col      <= {col[2:0], col[3]};
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // debounce and edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_code  <= '0;
            last_read  <= '0;
            stable_cnt <= '0;
            pressed    <= 1'b0;
            key_coord  <= '0;
        end else begin
            key_coord <= '0;                // pulse lasts one cycle
            if (scan_end) begin
                scan_code  <= '0;           // fresh start for the next scan
                last_read  <= reading;
                stable_cnt <= next_cnt;
                if (next_cnt == DB_FULL) begin
                    if (reading == '0) begin
                        pressed <= 1'b0;    // release confirmed
                    end else if (!pressed) begin
                        pressed   <= 1'b1;
                        key_coord <= reading;
                    end
                end
            end else if (col_end) begin
                scan_code <= reading;
            end
        end
    end

endmodule
